/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_addu = 4'b0001,
        alu_sub  = 4'b0010,
        alu_subu = 4'b0011,
        alu_and  = 4'b0100,
        alu_or   = 4'b0101,
        alu_xor  = 4'b0110,
        alu_nor  = 4'b0111,
        alu_slt  = 4'b1010,
        alu_sltu = 4'b1011
    } alu_fn_t;

    typedef enum logic [1:0] {
        shift_sll = 2'b00,
        shift_srl = 2'b01,
        shift_sra = 2'b10
    } shift_kind_t;

    typedef struct packed {
        logic        variable; // Amount from rs[4:0]
        shift_kind_t kind;
    } shift_t;

    typedef enum logic [1:0] {
        wb_alu   = 2'b00,
        wb_mem   = 2'b01,
        wb_shift = 2'b10,
        wb_link  = 2'b11  // pc+4
    } wb_sel_t;

    typedef enum logic [1:0] {
        pc_reg    = 2'b00, // jr, jalr
        pc_branch = 2'b01,
        pc_jump   = 2'b10,
        pc_seq    = 2'b11
    } pc_sel_t;

    typedef struct packed {
        alu_fn_t    alu_fn;
        logic       use_imm;
        logic       zero_ext;
        shift_t     shift;
        logic [4:0] dest;
        logic       reg_we;
        wb_sel_t    wb_sel;
        logic [3:0] branch_fn; // {opcode[2:0], instruction[16]}
        pc_sel_t    pc_sel;
        logic       mem_wren;
        logic       mem_rren;
    } ctrl_t;

    localparam logic [5:0] op_rtype  = 6'b000000;
    localparam logic [5:0] op_regimm = 6'b000001; // bltz, bgez
    localparam logic [5:0] op_j      = 6'b000010;
    localparam logic [5:0] op_jal    = 6'b000011;
    localparam logic [5:0] op_lw     = 6'b100011;
    localparam logic [5:0] op_sw     = 6'b101011;
    localparam logic [5:0] fn_jr     = 6'b001000;
    localparam logic [5:0] fn_jalr   = 6'b001001;

endpackage

`default_nettype wire

/* source/alu.sv */
`default_nettype none
`timescale 1ns/1ns

module alu (
    input  wire mips_pkg::alu_fn_t fn,
    input  wire [31:0]             a,
    input  wire [31:0]             b,
    output logic [31:0]            result
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic        less_signed;
    logic        less_unsigned;

    assign sum           = a + b; // Overflow ignored
    assign diff          = a - b;
    assign less_signed   = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    always_comb begin
        case (fn)
            mips_pkg::alu_add,
            mips_pkg::alu_addu: begin
                result = sum;
            end
            mips_pkg::alu_sub,
            mips_pkg::alu_subu: begin
                result = diff;
            end
            mips_pkg::alu_and: begin
                result = a & b;
            end
            mips_pkg::alu_or: begin
                result = a | b;
            end
            mips_pkg::alu_xor: begin
                result = a ^ b;
            end
            mips_pkg::alu_nor: begin
                result = ~(a | b);
            end
            mips_pkg::alu_slt: begin
                result = {31'd0, less_signed};
            end
            mips_pkg::alu_sltu: begin
                result = {31'd0, less_unsigned};
            end
            default: begin
                result = 32'd0; // Unused function codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/barrel_shifter.sv */
`default_nettype none
`timescale 1ns/1ns

module barrel_shifter (
    input  wire mips_pkg::shift_t shift,
    input  wire [4:0]             sa,
    input  wire [4:0]             rs_low,
    input  wire [31:0]            value,
    output logic [31:0]           result
);

    logic [4:0]  amount;
    logic        left;
    logic        fill;
    logic [31:0] stage;

    assign amount = shift.variable ? rs_low : sa;
    assign left   = shift.kind == mips_pkg::shift_sll;
    assign fill   = shift.kind == mips_pkg::shift_sra && value[31]; // Sign fill for sra

    // Five right-shift stages; a left shift runs on the bit-reversed word
    always_comb begin
        stage = left ? 32'({<<{value}}) : value;
        for (int i = 0; i < 5; i++) begin
            if (amount[i]) begin
                stage = (stage >> (1 << i)) | (fill ? ~(32'hffff_ffff >> (1 << i)) : 32'd0);
            end
        end
        result = left ? 32'({<<{stage}}) : stage;
    end

endmodule

`default_nettype wire

/* source/i_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

module i_decoder (
    input  wire  [31:0]    instruction,
    output logic [4:0]     rs,
    output logic [4:0]     rt,
    output logic [4:0]     sa,
    output logic [15:0]    imm,
    output logic [25:0]    iindex,
    output mips_pkg::ctrl_t ctrl
);

    typedef enum logic [1:0] {
        cls_i = 2'b00,
        cls_j = 2'b01,
        cls_r = 2'b10
    } iclass_t;

    logic [5:0] opc;
    logic [5:0] fun;
    logic [4:0] rd;
    iclass_t    iclass;
    logic       is_rtype;
    logic       is_jr;
    logic       is_jalr;
    logic       is_jal;
    logic       is_lw;
    logic       is_sw;
    logic       is_alu_imm;
    logic       is_branch;

    assign opc    = instruction[31:26];
    assign fun    = instruction[5:0];
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];
    assign rd     = instruction[15:11];
    assign sa     = instruction[10:6];
    assign imm    = instruction[15:0];
    assign iindex = instruction[25:0];

    function automatic iclass_t classify(input logic [5:0] op);
        casez (op)
            6'b001???, 6'b1???11, 6'b0001??, 6'b000001: classify = cls_i;
            6'b00001?: classify = cls_j;
            default: classify = cls_r;
        endcase
    endfunction

    assign iclass     = classify(opc);
    assign is_rtype   = opc == mips_pkg::op_rtype;
    assign is_jr      = is_rtype && fun == mips_pkg::fn_jr;
    assign is_jalr    = is_rtype && fun == mips_pkg::fn_jalr;
    assign is_jal     = opc == mips_pkg::op_jal;
    assign is_lw      = opc == mips_pkg::op_lw;
    assign is_sw      = opc == mips_pkg::op_sw;
    assign is_alu_imm = opc[5:3] == 3'b001; // addi .. xori
    assign is_branch  = opc[5:2] == 4'b0001 || opc == mips_pkg::op_regimm;

    always_comb begin
        if (is_lw || is_sw) begin
            ctrl.alu_fn = mips_pkg::alu_add; // Address calculation
        end else if (iclass == cls_r) begin
            ctrl.alu_fn = mips_pkg::alu_fn_t'(fun[3:0]);
        end else begin
            ctrl.alu_fn = mips_pkg::alu_fn_t'({~opc[2] & opc[1], opc[2:0]});
        end

        ctrl.use_imm  = iclass == cls_i;
        ctrl.zero_ext = opc[5:2] == 4'b0011; // andi, ori, xori

        ctrl.shift.variable = fun[2];
        case (fun[1:0])
            2'b10:   ctrl.shift.kind = mips_pkg::shift_srl;
            2'b11:   ctrl.shift.kind = mips_pkg::shift_sra;
            default: ctrl.shift.kind = mips_pkg::shift_sll;
        endcase

        if (is_jal || is_jalr) begin
            ctrl.dest = 5'd31;
        end else begin
            ctrl.dest = (iclass == cls_r) ? rd : rt;
        end

        ctrl.reg_we = is_alu_imm || is_lw || is_jal || (is_rtype && !is_jr);

        if (is_lw) begin
            ctrl.wb_sel = mips_pkg::wb_mem;
        end else if (is_jal || is_jalr) begin
            ctrl.wb_sel = mips_pkg::wb_link;
        end else if (is_rtype && fun[5:3] == 3'b000) begin
            ctrl.wb_sel = mips_pkg::wb_shift;
        end else begin
            ctrl.wb_sel = mips_pkg::wb_alu;
        end

        ctrl.branch_fn = {opc[2:0], instruction[16]};

        if (is_jr || is_jalr) begin
            ctrl.pc_sel = mips_pkg::pc_reg;
        end else if (is_branch) begin
            ctrl.pc_sel = mips_pkg::pc_branch;
        end else if (iclass == cls_j) begin
            ctrl.pc_sel = mips_pkg::pc_jump;
        end else begin
            ctrl.pc_sel = mips_pkg::pc_seq;
        end

        ctrl.mem_wren = is_sw;
        ctrl.mem_rren = is_lw;
    end

    always_comb begin
        assert final (!(ctrl.mem_wren && ctrl.mem_rren))
            else $error("load and store decoded from one instruction");
    end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none
`timescale 1ns/1ns

module register_file (
    input  wire         clk,
    input  wire         reset,
    input  wire  [4:0]  rs,
    input  wire  [4:0]  rt,
    input  wire  [4:0]  dest,
    input  wire         we,
    input  wire  [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];
    logic        write_en;

    assign write_en = we && dest != 5'd0; // r0 is never stored

    always_ff @(posedge clk) begin
        if (reset) begin
            regs[0] <= 32'd0; // Zero in r0 from reset on
        end else if (write_en) begin
            regs[dest] <= wdata;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

    // r0 reads as zero on both ports even after writes to it
    a_r0_zero: assert property (
        @(posedge clk) disable iff (reset)
        ((rs == 5'd0) |-> (rs_data == 32'd0)) and ((rt == 5'd0) |-> (rt_data == 32'd0))
    ) else $error("r0 read returned a nonzero value");

endmodule

`default_nettype wire

/* source/pc_unit.sv */
`default_nettype none
`timescale 1ns/1ns

module pc_unit #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire mips_pkg::pc_sel_t  pc_sel,
    input  wire [3:0]               branch_fn,
    input  wire [31:0]              rs_data,
    input  wire [31:0]              rt_data,
    input  wire [15:0]              imm,
    input  wire [25:0]              iindex,
    output logic [31:0]             pc,
    output logic [31:0]             pc_plus4
);

    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;
    logic        taken;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jump_target   = {pc_plus4[31:28], iindex, 2'b00};

    always_comb begin
        casez (branch_fn)
            4'b100?: taken = rs_data == rt_data;        // beq
            4'b101?: taken = rs_data != rt_data;        // bne
            4'b110?: taken = $signed(rs_data) <= 0;     // blez
            4'b111?: taken = $signed(rs_data) > 0;      // bgtz
            4'b0010: taken = rs_data[31];               // bltz
            4'b0011: taken = !rs_data[31];              // bgez
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (pc_sel)
            mips_pkg::pc_reg:    next_pc = rs_data;
            mips_pkg::pc_branch: next_pc = taken ? branch_target : pc_plus4;
            mips_pkg::pc_jump:   next_pc = jump_target;
            default:             next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_address;
        end else begin
            pc <= next_pc;
        end
    end

    // A misaligned jr target would show up here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

/* source/mips_core.sv */
`default_nettype none
`timescale 1ns/1ns

module mips_core #(
    parameter logic [31:0] reset_address = 32'h0000_0000
) (
    input  wire         clk,
    input  wire         reset,
    output logic [31:0] pc,
    input  wire  [31:0] instruction,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic        mem_wren,
    output logic        mem_rren,
    input  wire  [31:0] mem_rdata
);

    mips_pkg::ctrl_t ctrl;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      sa;
    logic [15:0]     imm;
    logic [25:0]     iindex;
    logic [31:0]     rs_data;
    logic [31:0]     rt_data;
    logic [31:0]     imm_ext;
    logic [31:0]     alu_b;
    logic [31:0]     alu_result;
    logic [31:0]     shift_result;
    logic [31:0]     pc_plus4;
    logic [31:0]     wb_data;

    i_decoder u_i_decoder (
        .instruction (instruction),
        .rs          (rs),
        .rt          (rt),
        .sa          (sa),
        .imm         (imm),
        .iindex      (iindex),
        .ctrl        (ctrl)
    );

    register_file u_register_file (
        .clk     (clk),
        .reset   (reset),        // Blocks writeback during reset
        .rs      (rs),
        .rt      (rt),
        .dest    (ctrl.dest),
        .we      (ctrl.reg_we),
        .wdata   (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign imm_ext = ctrl.zero_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign alu_b   = ctrl.use_imm ? imm_ext : rt_data;

    alu u_alu (
        .fn     (ctrl.alu_fn),
        .a      (rs_data),
        .b      (alu_b),
        .result (alu_result)
    );

    barrel_shifter u_barrel_shifter (
        .shift  (ctrl.shift),
        .sa     (sa),
        .rs_low (rs_data[4:0]),
        .value  (rt_data),
        .result (shift_result)
    );

    pc_unit #(
        .reset_address (reset_address)
    ) u_pc_unit (
        .clk       (clk),
        .reset     (reset),
        .pc_sel    (ctrl.pc_sel),
        .branch_fn (ctrl.branch_fn),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .imm       (imm),
        .iindex    (iindex),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    always_comb begin
        case (ctrl.wb_sel)
            mips_pkg::wb_mem:   wb_data = mem_rdata;
            mips_pkg::wb_shift: wb_data = shift_result;
            mips_pkg::wb_link:  wb_data = pc_plus4; // jal, jalr return address
            default:            wb_data = alu_result;
        endcase
    end

    assign mem_addr  = alu_result;
    assign mem_wdata = rt_data;
    assign mem_wren  = ctrl.mem_wren && !reset; // No stores while in reset
    assign mem_rren  = ctrl.mem_rren;

    a_mem_aligned: assert property (
        @(posedge clk) disable iff (reset)
        (mem_wren || mem_rren) |-> mem_addr[1:0] == 2'b00
    ) else $error("unaligned data access at %h", mem_addr);

endmodule

`default_nettype wire

/* verification/mips_core_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module mips_core_tb;

    localparam logic [31:0] reset_address = 32'h0000_0100;
    localparam int max_cycles = 3000; // Six short programs plus reset, well under this

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instruction;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_wren;
    logic        mem_rren;
    logic [31:0] mem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] init_mem [256];
    logic [31:0] exp_trace [$];
    logic [31:0] trace [$];
    logic [31:0] store_addr [$];
    logic [31:0] store_val [$];
    logic [31:0] cur_addr;
    logic [31:0] end_pc;
    integer      seed;
    int          cycles;

    mips_core #(
        .reset_address (reset_address)
    ) u_mips_core (
        .clk         (clk),
        .reset       (reset),
        .pc          (pc),
        .instruction (instruction),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wren    (mem_wren),
        .mem_rren    (mem_rren),
        .mem_rdata   (mem_rdata)
    );

    assign instruction = imem[pc[9:2]];
    assign mem_rdata   = dmem[mem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_wren) begin
            dmem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: program did not reach its end after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sa,
                                          input logic [5:0] fn);
        return {mips_pkg::op_rtype, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] alu_expect(input logic [5:0] fn, input logic [31:0] a,
                                               input logic [31:0] b);
        case (fn)
            6'h20, 6'h21: return a + b;
            6'h22, 6'h23: return a - b;
            6'h24:        return a & b;
            6'h25:        return a | b;
            6'h26:        return a ^ b;
            6'h27:        return ~(a | b);
            6'h2a:        return {31'd0, $signed(a) < $signed(b)};
            default:      return {31'd0, a < b}; // sltu
        endcase
    endfunction

    function automatic logic [31:0] shift_expect(input logic [5:0] fn, input logic [31:0] v,
                                                 input logic [4:0] amt);
        case (fn[1:0])
            2'b00:   return v << amt;
            2'b10:   return v >> amt;
            default: return $unsigned($signed(v) >>> amt);
        endcase
    endfunction

    function automatic bit branch_expect(input logic [5:0] op, input logic [4:0] rtf,
                                         input logic [31:0] a, input logic [31:0] b);
        case (op)
            6'h04:   return a == b;
            6'h05:   return a != b;
            6'h06:   return $signed(a) <= 0;
            6'h07:   return $signed(a) > 0;
            default: return rtf[0] ? !a[31] : a[31]; // bgez / bltz
        endcase
    endfunction

    // Every unused word jumps to itself, so a stray pc stalls and times out
    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_j(mips_pkg::op_j, i * 4);
        end
        cur_addr = reset_address;
        exp_trace.delete();
        store_addr.delete();
        store_val.delete();
    endtask

    task automatic emit(input logic [31:0] word, input bit on_path);
        imem[cur_addr[9:2]] = word;
        if (on_path) begin
            exp_trace.push_back(cur_addr);
        end
        cur_addr = cur_addr + 4;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] value);
        store_addr.push_back(addr);
        store_val.push_back(value);
    endtask

    task automatic finish_program();
        end_pc = cur_addr;
        emit(enc_j(mips_pkg::op_j, end_pc), 1);
    endtask

    task automatic seed_data();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
            init_mem[i] = dmem[i];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    // pc is sampled mid-cycle, away from the edge that updates it
    task automatic run_program(input string name);
        trace.delete();
        do begin
            @(negedge clk);
            trace.push_back(pc);
            check({name, " load enable"}, instruction[31:26] == mips_pkg::op_lw, mem_rren);
            check({name, " store enable"}, instruction[31:26] == mips_pkg::op_sw, mem_wren);
        end while (pc != end_pc);
        check({name, " trace length"}, exp_trace.size(), trace.size());
        foreach (exp_trace[i]) begin
            check({name, " pc trace"}, exp_trace[i], trace[i]);
        end
        foreach (store_addr[i]) begin
            check({name, " stored word"}, store_val[i], dmem[store_addr[i][9:2]]);
        end
    endtask

    task automatic alu_test();
        logic [5:0]  r_fn [10];
        logic [5:0]  i_op [7];
        logic [5:0]  i_fn [7];
        logic [15:0] imm_val [2];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] slot;
        r_fn = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        i_op = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e};
        i_fn = '{6'h20, 6'h21, 6'h2a, 6'h2b, 6'h24, 6'h25, 6'h26};
        imm_val = '{16'h8a3c, 16'h1234}; // Negative and positive
        new_program();
        seed_data();
        a = init_mem[0];
        b = init_mem[1];
        slot = 32'h200;
        emit(enc_i(mips_pkg::op_lw, 0, 1, 16'h0000), 1);
        emit(enc_i(mips_pkg::op_lw, 0, 2, 16'h0004), 1);
        foreach (r_fn[k]) begin
            emit(enc_r(1, 2, 3, 0, r_fn[k]), 1);
            emit(enc_i(mips_pkg::op_sw, 0, 3, slot[15:0]), 1);
            expect_store(slot, alu_expect(r_fn[k], a, b));
            slot = slot + 4;
        end
        foreach (imm_val[m]) begin
            foreach (i_op[k]) begin
                b = (i_op[k] >= 6'h0c) ? {16'd0, imm_val[m]} : {{16{imm_val[m][15]}}, imm_val[m]};
                emit(enc_i(i_op[k], 1, 3, imm_val[m]), 1);
                emit(enc_i(mips_pkg::op_sw, 0, 3, slot[15:0]), 1);
                expect_store(slot, alu_expect(i_fn[k], a, b));
                slot = slot + 4;
            end
        end
        finish_program();
        apply_reset();
        run_program("alu");
    endtask

    task automatic shift_test();
        logic [5:0]  fns [6];
        logic [4:0]  sa;
        logic [4:0]  amt;
        logic [31:0] slot;
        fns = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
        new_program();
        seed_data();
        dmem[0][31] = 1'b1; // One negative and one positive value for sra
        dmem[1][31] = 1'b0;
        init_mem[0] = dmem[0];
        init_mem[1] = dmem[1];
        sa = $random(seed);
        slot = 32'h200;
        emit(enc_i(mips_pkg::op_lw, 0, 1, 16'h0000), 1);
        emit(enc_i(mips_pkg::op_lw, 0, 2, 16'h0004), 1);
        emit(enc_i(mips_pkg::op_lw, 0, 4, 16'h0008), 1);
        for (int v = 0; v < 2; v++) begin
            foreach (fns[k]) begin
                amt = fns[k][2] ? init_mem[2][4:0] : sa;
                emit(enc_r(4, 5'(v + 1), 3, sa, fns[k]), 1);
                emit(enc_i(mips_pkg::op_sw, 0, 3, slot[15:0]), 1);
                expect_store(slot, shift_expect(fns[k], init_mem[v], amt));
                slot = slot + 4;
            end
        end
        finish_program();
        apply_reset();
        run_program("shift");
    endtask

    task automatic mem_test();
        new_program();
        seed_data();
        emit(enc_i(6'h08, 0, 5, 16'h0100), 1);
        emit(enc_i(mips_pkg::op_lw, 5, 6, 16'hfff8), 1);
        emit(enc_i(mips_pkg::op_sw, 5, 6, 16'h0010), 1);
        emit(enc_i(mips_pkg::op_lw, 5, 7, 16'h0020), 1);
        emit(enc_i(mips_pkg::op_sw, 5, 7, 16'hffc0), 1);
        emit(enc_i(6'h08, 0, 0, 16'h0055), 1);
        emit(enc_r(6, 7, 0, 0, 6'h20), 1);
        emit(enc_i(mips_pkg::op_sw, 5, 0, 16'h0014), 1);
        expect_store(32'h110, init_mem[32'hf8 >> 2]);
        expect_store(32'h0c0, init_mem[32'h120 >> 2]);
        expect_store(32'h114, 32'd0);
        finish_program();
        apply_reset();
        run_program("load store");
    endtask

    task automatic branch_test();
        logic [5:0]  ops [13];
        logic [4:0]  rss [13];
        logic [4:0]  rts [13];
        logic [31:0] regv [4];
        bit          taken;
        ops = '{6'h04, 6'h04, 6'h05, 6'h05, 6'h06, 6'h06, 6'h06,
                6'h07, 6'h07, 6'h01, 6'h01, 6'h01, 6'h01};
        rss = '{1, 1, 1, 1, 3, 1, 0, 1, 0, 3, 0, 0, 3};
        rts = '{2, 3, 3, 2, 0, 0, 0, 0, 0, 0, 0, 1, 1};
        regv = '{32'd0, 32'd5, 32'd5, 32'hffff_fffd};
        new_program();
        emit(enc_i(6'h08, 0, 1, 16'd5), 1);
        emit(enc_i(6'h08, 0, 2, 16'd5), 1);
        emit(enc_i(6'h08, 0, 3, 16'hfffd), 1);
        foreach (ops[k]) begin
            taken = branch_expect(ops[k], rts[k], regv[rss[k]], regv[rts[k]]);
            emit(enc_i(ops[k], rss[k], rts[k], 16'd2), 1); // Skips two words when taken
            emit(32'd0, !taken);
            emit(32'd0, !taken);
        end
        finish_program();
        apply_reset();
        run_program("branch");
    endtask

    task automatic jump_test();
        logic [31:0] base;
        new_program();
        base = cur_addr;
        emit(enc_i(6'h08, 0, 8, 16'(base + 36)), 1);
        emit(enc_i(6'h08, 0, 9, 16'(base + 44)), 1);
        emit(enc_j(mips_pkg::op_jal, base + 16), 1);
        emit(32'd0, 0);
        emit(enc_i(mips_pkg::op_sw, 0, 31, 16'h0300), 1);
        emit(enc_j(mips_pkg::op_j, base + 28), 1);
        emit(32'd0, 0);
        emit(enc_r(8, 0, 0, 0, mips_pkg::fn_jr), 1);
        emit(32'd0, 0);
        emit(enc_r(9, 0, 31, 0, mips_pkg::fn_jalr), 1);
        emit(32'd0, 0);
        emit(enc_i(mips_pkg::op_sw, 0, 31, 16'h0304), 1);
        expect_store(32'h300, base + 12);
        expect_store(32'h304, base + 40);
        finish_program();
        apply_reset();
        run_program("jump");
    endtask

    task automatic reset_test();
        new_program();
        seed_data();
        emit(enc_i(6'h08, 0, 1, 16'h0077), 1);
        emit(enc_i(mips_pkg::op_sw, 0, 1, 16'h0380), 1);
        emit(enc_i(mips_pkg::op_sw, 0, 1, 16'h0384), 1);
        expect_store(32'h380, 32'h77);
        expect_store(32'h384, 32'h77);
        finish_program();
        apply_reset();
        @(negedge clk);
        check("reset start", reset_address, pc);
        @(posedge clk);
        reset <= 1'b1; // Lands while the first store is current
        repeat (4) begin
            @(negedge clk);
            check("reset store gate", 32'd0, {31'd0, mem_wren});
            check("reset memory", init_mem[32'h380 >> 2], dmem[32'h380 >> 2]);
        end
        @(posedge clk);
        reset <= 1'b0;
        run_program("reset");
    endtask

    initial begin
        reset = 1'b1;
        cycles = 0;
        seed = 32'h3e97c51b;
        alu_test();
        shift_test();
        mem_test();
        branch_test();
        jump_test();
        reset_test();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/mips_pkg.sv
source/alu.sv
source/barrel_shifter.sv
source/i_decoder.sv
source/register_file.sv
source/pc_unit.sv
source/mips_core.sv
verification/mips_core_tb.sv
